//--- list.f
hdl/rv_pkg.sv
hdl/rv_ifs.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_datapath.sv
hdl/rv_ctlpath.sv
hdl/rv_dmem_if.sv
hdl/rv_core.sv
test/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
  -f list.f -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  exit 1
fi
exit 0

//--- test/tb_rv_core.sv
/*
  Self-checking testbench for rv_core running a random RV32I program
  Both memories hold 256 words and wrap on address bits 9:2
  Half and word accesses in the program are naturally aligned
*/
module tb_rv_core;
  import rv_pkg::*;

  logic        clock;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] bus_read_data;
  logic [31:0] pc;
  logic [31:0] bus_address;
  logic [31:0] bus_write_data;
  logic [3:0]  bus_byte_enable;
  logic        bus_read_enable;
  logic        bus_write_enable;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  int          prog_len;
  logic [31:0] end_pc;
  int          cycles;

  // Shadow state of the reference model
  logic [31:0] m_pc;
  logic [31:0] m_regs [0:31];
  logic [31:0] m_mem [0:255];
  // Expected bus activity for the current cycle
  logic        exp_read;
  logic        exp_write;
  logic [31:0] exp_addr;
  logic [3:0]  exp_be;
  logic [31:0] exp_wdata;

  rv_core DUT (
    .clock            (clock),
    .rst_n            (rst_n),
    .inst             (inst),
    .bus_read_data    (bus_read_data),
    .pc               (pc),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  always #50 clock = ~clock;

  // ----------------------------------------
  // Zero-wait memories
  assign inst          = imem[pc[9:2]];
  assign bus_read_data = dmem[bus_address[9:2]];

  always @(posedge clock) begin
    if (bus_write_enable) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_byte_enable[i]) begin
          dmem[bus_address[9:2]][8*i +: 8] <= bus_write_data[8*i +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  // ----------------------------------------
  // Program generator
  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(15, 1));
  endfunction

  // Random data address aligned to the access size
  function automatic logic [11:0] data_offset(input logic [2:0] f3);
    logic [11:0] offset;
    offset = {2'b00, 8'($urandom), 2'b00};
    case (f3[1:0])
      2'b00:   offset[1:0] = 2'($urandom);
      2'b01:   offset[1] = 1'($urandom);
      default: ;
    endcase
    return offset;
  endfunction

  // Stores a register so its value shows up on the bus
  task automatic save_reg(input logic [4:0] r);
    emit(s_type(data_offset(3'b010), r, 5'd0, 3'b010));
  endtask

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    int          kind;
    prog_len = 0;
    // Store at the reset PC that reset has to keep off the bus
    save_reg(5'd0);
    // x1..x15 get random start values
    for (int r = 1; r < 16; r++) begin
      emit({20'($urandom), 5'(r), opc_lui});
      emit(i_type(12'($urandom), 5'(r), 3'b000, 5'(r), opc_op_imm));
    end
    while (prog_len < 240) begin
      kind = $urandom_range(6, 0);
      rd   = rand_reg();
      rs1  = rand_reg();
      rs2  = rand_reg();
      f3   = 3'($urandom);
      alt  = 1'($urandom);
      case (kind)
        0: begin
          emit(r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd));
          save_reg(rd);
        end
        1: begin
          imm = 12'($urandom);
          // Shift immediates carry only shamt and the SRA bit
          if (f3 == 3'b001) imm = {7'h00, imm[4:0]};
          if (f3 == 3'b101) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
          emit(i_type(imm, rs1, f3, rd, opc_op_imm));
          save_reg(rd);
        end
        2: begin
          // LB LH LW LBU LHU
          f3 = 3'($urandom_range(4, 0));
          f3 = (f3 > 3'd2) ? f3 + 3'd1 : f3;
          emit(i_type(data_offset(f3), 5'd0, f3, rd, opc_load));
          save_reg(rd);
        end
        3: begin
          f3 = 3'($urandom_range(2, 0));
          emit(s_type(data_offset(f3), rs2, 5'd0, f3));
        end
        4: begin
          f3 = 3'($urandom_range(5, 0));
          f3 = (f3 > 3'd1) ? f3 + 3'd2 : f3;
          // Equal operands half the time
          if (alt) rs2 = rs1;
          emit(b_type(13'd8, rs2, rs1, f3));
          emit(i_type(12'd1, rd, 3'b000, rd, opc_op_imm));
          save_reg(rd);
        end
        5: begin
          emit(j_type(21'd8, rd));
          emit(i_type(12'd1, rs1, 3'b000, rs1, opc_op_imm));
          save_reg(rd);
        end
        default: begin
          // Target is auipc + 13 with bit 0 dropped so one word is skipped
          emit({20'd0, 5'd30, opc_auipc});
          emit(i_type(12'd13, 5'd30, 3'b000, rd, opc_jalr));
          emit(i_type(12'd1, rs1, 3'b000, rs1, opc_op_imm));
          save_reg(rd);
        end
      endcase
    end
    end_pc = {22'd0, 8'(prog_len), 2'b00};
    emit(j_type(21'd0, 5'd0));
  endtask

  // ----------------------------------------
  // Reference model
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] arith;
    arith = $signed(a) >>> b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? arith : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Runs one instruction on the shadow state and records the expected bus cycle
  function automatic void model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] addr;
    logic [31:0] lanes;
    logic [31:0] wb;
    logic [31:0] next;
    logic [2:0]  f3;
    logic        taken;
    logic        write_rd;
    ins      = imem[m_pc[9:2]];
    f3       = ins[14:12];
    a        = m_regs[ins[19:15]];
    b        = m_regs[ins[24:20]];
    imm_i    = {{20{ins[31]}}, ins[31:20]};
    imm_b    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    next     = m_pc + 32'd4;
    wb       = next;
    write_rd = 1'b1;
    taken    = 1'b0;
    exp_read  = 1'b0;
    exp_write = 1'b0;
    exp_addr  = '0;
    exp_be    = '0;
    exp_wdata = '0;
    case (ins[6:0])
      opc_lui:   wb = {ins[31:12], 12'd0};
      opc_auipc: wb = m_pc + {ins[31:12], 12'd0};
      opc_jal:   next = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      opc_jalr:  next = (a + imm_i) & ~32'd1;
      opc_branch: begin
        write_rd = 1'b0;
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) next = m_pc + imm_b;
      end
      opc_load: begin
        addr     = a + imm_i;
        lanes    = m_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        exp_read = 1'b1;
        exp_addr = {addr[31:2], 2'b00};
        case (f3[1:0])
          2'b00: begin
            exp_be = 4'b0001 << addr[1:0];
            wb     = f3[2] ? {24'd0, lanes[7:0]} : {{24{lanes[7]}}, lanes[7:0]};
          end
          2'b01: begin
            exp_be = addr[1] ? 4'b1100 : 4'b0011;
            wb     = f3[2] ? {16'd0, lanes[15:0]} : {{16{lanes[15]}}, lanes[15:0]};
          end
          default: begin
            exp_be = 4'b1111;
            wb     = lanes;
          end
        endcase
      end
      opc_store: begin
        write_rd  = 1'b0;
        addr      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_write = 1'b1;
        exp_addr  = {addr[31:2], 2'b00};
        case (f3[1:0])
          2'b00: begin
            exp_be    = 4'b0001 << addr[1:0];
            exp_wdata = {24'd0, b[7:0]} << {addr[1:0], 3'b000};
          end
          2'b01: begin
            exp_be    = addr[1] ? 4'b1100 : 4'b0011;
            exp_wdata = {16'd0, b[15:0]} << {addr[1], 4'b0000};
          end
          default: begin
            exp_be    = 4'b1111;
            exp_wdata = b;
          end
        endcase
        for (int i = 0; i < 4; i++) begin
          if (exp_be[i]) m_mem[addr[9:2]][8*i +: 8] = exp_wdata[8*i +: 8];
        end
      end
      opc_op_imm: wb = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
      opc_op:     wb = alu_ref(f3, ins[30], a, b);
      default:    write_rd = 1'b0;
    endcase
    if (write_rd && ins[11:7] != 5'd0) m_regs[ins[11:7]] = wb;
    m_pc = next;
  endfunction

  // ----------------------------------------
  // Checking
  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s expected %h actual %h", test_name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first error, cycle %0d", cycles);
    end
  endtask

  task automatic compare_bus();
    logic [31:0] lane_mask;
    for (int i = 0; i < 4; i++) begin
      lane_mask[8*i +: 8] = {8{exp_be[i]}};
    end
    check_value("both strobes", 32'd0, {31'd0, bus_read_enable & bus_write_enable});
    check_value("read strobe", {31'd0, exp_read}, {31'd0, bus_read_enable});
    check_value("write strobe", {31'd0, exp_write}, {31'd0, bus_write_enable});
    if (exp_read || exp_write) begin
      check_value("bus address", exp_addr, bus_address);
      check_value("byte enable", {28'd0, exp_be}, {28'd0, bus_byte_enable});
    end
    // Only enabled lanes carry meaning
    if (exp_write) begin
      check_value("write data", exp_wdata & lane_mask, bus_write_data & lane_mask);
    end
  endtask

  initial begin
    logic [31:0] word;
    void'($urandom(32'h93fcc43b));
    clock  = 1'b0;
    rst_n  = 1'b0;
    cycles = 0;
    // Unused code words are NOPs tagged with their index
    for (int i = 0; i < 256; i++) begin
      imem[i]   = i_type(12'(i), 5'd0, 3'b000, 5'd0, opc_op_imm);
      word      = $urandom;
      dmem[i]  <= word;
      m_mem[i]  = word;
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = reset_pc;
    build_program();

    // Nothing may reach the bus during reset
    repeat (10) begin
      @(negedge clock);
      check_value("reset pc", reset_pc, pc);
      check_value("reset strobes", 32'd0, {30'd0, bus_read_enable, bus_write_enable});
      check_value("reset byte enable", 32'd0, {28'd0, bus_byte_enable});
    end
    rst_n = 1'b1;
    #10;

    // One instruction per cycle against the model
    while (pc !== end_pc && cycles < 2000) begin
      check_value("pc", m_pc, pc);
      model_step();
      compare_bus();
      @(negedge clock);
      #10;
      cycles++;
    end

    if (cycles >= 2000) begin
      $display("program did not reach its end within 2000 cycles");
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout while running the program");
    end else begin
      check_value("final pc", m_pc, pc);
      for (int i = 0; i < 256; i++) begin
        check_value("data memory", m_mem[i], dmem[i]);
      end
      $display("TEST RESULT: PASS");
      $finish;
    end
  end
endmodule

//--- hdl/rv_core.sv
/*
  Single-cycle RV32I core, one instruction retired per clock
  Instruction and data buses must answer within the same cycle
  No FENCE, system instructions, CSRs or traps
*/
module rv_core (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] inst,
  input  logic [rv_pkg::xlen-1:0] bus_read_data,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] bus_address,
  output logic [rv_pkg::xlen-1:0] bus_write_data,
  output logic [3:0]              bus_byte_enable,
  output logic                    bus_read_enable,
  output logic                    bus_write_enable
);

  // Internal bundles
  rv_ctl_if ctl_bus (.clock(clock));
  rv_mem_if mem_bus ();

  // PC, register file, ALU
  rv_datapath datapath (
    .clock (clock),
    .rst_n (rst_n),
    .inst  (inst),
    .ctl   (ctl_bus.dp),
    .mem   (mem_bus.dp),
    .pc    (pc)
  );

  // Decode and branch resolution
  rv_ctlpath ctlpath (
    .rst_n (rst_n),
    .ctl   (ctl_bus.ctl)
  );

  // Lane handling toward the data bus
  rv_dmem_if dmem (
    .ctl              (ctl_bus.mem),
    .mem              (mem_bus.mem),
    .bus_read_data    (bus_read_data),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );
endmodule

//--- hdl/rv_dmem_if.sv
/*
  Data bus unit: word-aligned address, lane select, load extension
  Halves use address bit 1 only, words ignore the low bits
*/
module rv_dmem_if (
  rv_ctl_if.mem                   ctl,
  rv_mem_if.mem                   mem,
  input  logic [rv_pkg::xlen-1:0] bus_read_data,
  output logic [rv_pkg::xlen-1:0] bus_address,
  output logic [rv_pkg::xlen-1:0] bus_write_data,
  output logic [3:0]              bus_byte_enable,
  output logic                    bus_read_enable,
  output logic                    bus_write_enable
);
  import rv_pkg::*;

  logic [1:0]      lane;
  logic [3:0]      lane_mask;
  logic [xlen-1:0] shifted;

  assign lane             = mem.address[1:0];
  assign bus_address      = {mem.address[xlen-1:2], 2'b00};
  assign bus_read_enable  = ctl.mem_read;
  assign bus_write_enable = ctl.mem_write;

  // ----------------------------------------
  // Store side, data replicated so any lane sees it
  always_comb begin
    case (ctl.funct3)
      fmt_byte, fmt_byte_u: begin
        bus_write_data = {4{mem.write_data[7:0]}};
        lane_mask      = 4'b0001 << lane;
        shifted        = bus_read_data >> {lane, 3'b000};
      end
      fmt_half, fmt_half_u: begin
        bus_write_data = {2{mem.write_data[15:0]}};
        lane_mask      = lane[1] ? 4'b1100 : 4'b0011;
        shifted        = bus_read_data >> {lane[1], 4'b0000};
      end
      default: begin
        bus_write_data = mem.write_data;
        lane_mask      = 4'b1111;
        shifted        = bus_read_data;
      end
    endcase
  end

  // Enables only on an actual access
  assign bus_byte_enable = (ctl.mem_read || ctl.mem_write) ? lane_mask : 4'b0000;

  // ----------------------------------------
  // Load side, addressed lane moved down and extended
  always_comb begin
    case (ctl.funct3)
      fmt_byte:   mem.read_data = {{24{shifted[7]}}, shifted[7:0]};
      fmt_half:   mem.read_data = {{16{shifted[15]}}, shifted[15:0]};
      fmt_byte_u: mem.read_data = {24'b0, shifted[7:0]};
      fmt_half_u: mem.read_data = {16'b0, shifted[15:0]};
      fmt_word:   mem.read_data = shifted;
      default:    mem.read_data = shifted;
    endcase
  end

  write_has_lanes: assert property (@(posedge ctl.clock)
    bus_write_enable |-> (bus_byte_enable != 4'b0000));
endmodule

//--- hdl/rv_ctlpath.sv
/*
  Control path: opcode decode, ALU control and branch resolution
  Unknown opcodes execute as no-ops, strobes held low in reset
*/
module rv_ctlpath (
  input logic   rst_n,
  rv_ctl_if.ctl ctl
);
  import rv_pkg::*;

  alu_fn_t reg_op_fn;
  alu_fn_t branch_fn;
  logic    branch_taken;
  logic    alt;

  // funct7 bit 5 selects SUB and SRA
  assign alt = ctl.funct7[5];

  // ----------------------------------------
  // ALU function for OP and OP-IMM
  always_comb begin
    case (ctl.funct3)
      // No SUBI, so alt only counts on OP
      f3_add_sub: reg_op_fn = (ctl.opcode == opc_op && alt) ? alu_sub : alu_add;
      f3_sll:     reg_op_fn = alu_sll;
      f3_slt:     reg_op_fn = alu_slt;
      f3_sltu:    reg_op_fn = alu_sltu;
      f3_xor:     reg_op_fn = alu_xor;
      f3_srl_sra: reg_op_fn = alt ? alu_sra : alu_srl;
      f3_or:      reg_op_fn = alu_or;
      f3_and:     reg_op_fn = alu_and;
      default:    reg_op_fn = alu_add;
    endcase
  end

  // Branch compare, equality by SUB, ordering by SLT/SLTU
  always_comb begin
    case (ctl.funct3)
      f3_blt, f3_bge:   branch_fn = alu_slt;
      f3_bltu, f3_bgeu: branch_fn = alu_sltu;
      default:          branch_fn = alu_sub;
    endcase
  end

  // Taken from the zero flag
  always_comb begin
    case (ctl.funct3)
      f3_beq, f3_bge, f3_bgeu: branch_taken = ctl.alu_zero;
      f3_bne, f3_blt, f3_bltu: branch_taken = !ctl.alu_zero;
      default:                 branch_taken = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Main decoder
  always_comb begin
    ctl.alu_function = alu_add;
    ctl.op_a_sel     = op_a_rs1;
    ctl.op_b_sel     = op_b_imm;
    ctl.wb_sel       = wb_alu;
    ctl.next_pc_sel  = npc_plus4;
    ctl.reg_write    = 1'b0;
    ctl.mem_read     = 1'b0;
    ctl.mem_write    = 1'b0;
    case (ctl.opcode)
      opc_lui: begin
        ctl.alu_function = alu_pass_b;
        ctl.reg_write    = 1'b1;
      end
      opc_auipc: begin
        ctl.op_a_sel  = op_a_pc;
        ctl.reg_write = 1'b1;
      end
      opc_jal: begin
        ctl.wb_sel      = wb_pc4;
        ctl.next_pc_sel = npc_branch;
        ctl.reg_write   = 1'b1;
      end
      opc_jalr: begin
        ctl.wb_sel      = wb_pc4;
        ctl.next_pc_sel = npc_jalr;
        ctl.reg_write   = 1'b1;
      end
      opc_branch: begin
        ctl.op_b_sel     = op_b_rs2;
        ctl.alu_function = branch_fn;
        ctl.next_pc_sel  = branch_taken ? npc_branch : npc_plus4;
      end
      opc_load: begin
        ctl.wb_sel    = wb_load;
        ctl.mem_read  = 1'b1;
        ctl.reg_write = 1'b1;
      end
      opc_store: ctl.mem_write = 1'b1;
      opc_op_imm: begin
        ctl.alu_function = reg_op_fn;
        ctl.reg_write    = 1'b1;
      end
      opc_op: begin
        ctl.op_b_sel     = op_b_rs2;
        ctl.alu_function = reg_op_fn;
        ctl.reg_write    = 1'b1;
      end
      default: ;
    endcase
    // Nothing commits while in reset
    if (!rst_n) begin
      ctl.reg_write = 1'b0;
      ctl.mem_read  = 1'b0;
      ctl.mem_write = 1'b0;
    end
  end

  no_read_and_write: assert property (@(posedge ctl.clock) disable iff (!rst_n)
    !(ctl.mem_read && ctl.mem_write));
endmodule

//--- hdl/rv_datapath.sv
/*
  Datapath: PC register, field split, immediates, operand and PC muxes
  PC resets asynchronously to reset_pc, no stall input
*/
module rv_datapath (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] inst,
  rv_ctl_if.dp                    ctl,
  rv_mem_if.dp                    mem,
  output logic [rv_pkg::xlen-1:0] pc
);
  import rv_pkg::*;

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;

  // ----------------------------------------
  // Decode fields
  assign ctl.opcode = opcode_t'(inst[6:0]);
  assign ctl.funct3 = inst[14:12];
  assign ctl.funct7 = inst[31:25];

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (ctl.opcode)
      opc_store:          imm = imm_s;
      opc_branch:         imm = imm_b;
      opc_lui, opc_auipc: imm = imm_u;
      opc_jal:            imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  // ----------------------------------------
  // Register file and ALU
  rv_regfile regfile (
    .clock        (clock),
    .rst_n        (rst_n),
    .rs1_addr     (inst[19:15]),
    .rs2_addr     (inst[24:20]),
    .rd_addr      (inst[11:7]),
    .rd_data      (rd_data),
    .write_enable (ctl.reg_write),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (ctl.op_a_sel == op_a_pc) ? pc : rs1_data;
  assign operand_b = (ctl.op_b_sel == op_b_imm) ? imm : rs2_data;

  rv_alu alu (
    .alu_function (ctl.alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .result       (alu_result),
    .zero         (ctl.alu_zero)
  );

  // Effective address and store data
  assign mem.address    = alu_result;
  assign mem.write_data = rs2_data;

  // ----------------------------------------
  // Writeback and next PC
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctl.wb_sel)
      wb_load: rd_data = mem.read_data;
      wb_pc4:  rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctl.next_pc_sel)
      npc_branch: next_pc = pc + imm;
      // JALR target drops bit 0
      npc_jalr:   next_pc = {alu_result[xlen-1:1], 1'b0};
      default:    next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end
endmodule

//--- hdl/rv_alu.sv
/*
  Integer ALU for RV32I, purely combinational
  Shift amount is the low 5 bits of operand_b
*/
module rv_alu (
  input  rv_pkg::alu_fn_t         alu_function,
  input  logic [rv_pkg::xlen-1:0] operand_a,
  input  logic [rv_pkg::xlen-1:0] operand_b,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    zero
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b[4:0];
  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_function)
      alu_add:    result = operand_a + operand_b;
      alu_sub:    result = operand_a - operand_b;
      alu_sll:    result = operand_a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    result = operand_a ^ operand_b;
      alu_srl:    result = operand_a >> shamt;
      // Arithmetic shift keeps the sign
      alu_sra:    result = $unsigned($signed(operand_a) >>> shamt);
      alu_or:     result = operand_a | operand_b;
      alu_and:    result = operand_a & operand_b;
      alu_pass_b: result = operand_b;
      default:    result = operand_a + operand_b;
    endcase
  end

  // Branch resolution uses this
  assign zero = (result == '0);
endmodule

//--- hdl/rv_regfile.sv
/*
  32 x 32 integer register file, two async reads and one write
  x0 is never written, so it reads zero after reset
*/
module rv_regfile (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [4:0]              rd_addr,
  input  logic [rv_pkg::xlen-1:0] rd_data,
  input  logic                    write_enable,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [0:31];

  // Combinational read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Write guard must keep x0 at zero across every cycle
  x0_reads_zero: assert property (@(posedge clock) disable iff (!rst_n)
    (rs1_addr == 5'd0) |-> (rs1_data == '0));
endmodule

//--- hdl/rv_ifs.sv
/*
  Internal bundles between datapath, control path and memory unit
  No handshakes, every signal is valid within the current cycle
*/

// Decode fields out, control selects back
interface rv_ctl_if (input logic clock);
  import rv_pkg::*;

  opcode_t                 opcode;
  logic [funct3_width-1:0] funct3;
  logic [funct7_width-1:0] funct7;
  logic                    alu_zero;
  alu_fn_t                 alu_function;
  op_a_sel_t               op_a_sel;
  op_b_sel_t               op_b_sel;
  wb_sel_t                 wb_sel;
  next_pc_sel_t            next_pc_sel;
  logic                    reg_write;
  logic                    mem_read;
  logic                    mem_write;

  modport ctl (
    input  clock, opcode, funct3, funct7, alu_zero,
    output alu_function, op_a_sel, op_b_sel, wb_sel, next_pc_sel,
    output reg_write, mem_read, mem_write
  );
  modport dp (
    output opcode, funct3, funct7, alu_zero,
    input  alu_function, op_a_sel, op_b_sel, wb_sel, next_pc_sel, reg_write
  );
  modport mem (input clock, mem_read, mem_write, funct3);
endinterface

// Data access from the datapath, load data comes back already extended
interface rv_mem_if;
  import rv_pkg::*;

  logic [xlen-1:0] address;
  logic [xlen-1:0] write_data;
  logic [xlen-1:0] read_data;

  modport dp (output address, write_data, input read_data);
  modport mem (input address, write_data, output read_data);
endinterface

//--- hdl/rv_pkg.sv
/*
  Shared constants and encodings for the single-cycle RV32I core
  XLEN is fixed at 32, reset vector is address 0
*/
package rv_pkg;

  // ----------------------------------------
  // Widths and reset vector
  localparam int xlen         = 32;
  localparam int opcode_width = 7;
  localparam int funct3_width = 3;
  localparam int funct7_width = 7;
  localparam logic [xlen-1:0] reset_pc = '0;

  // ----------------------------------------
  // Major opcodes, RV32I base only
  typedef enum logic [opcode_width-1:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  // ALU operations, pass_b serves LUI
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_fn_t;

  // Datapath mux selects
  typedef enum logic {op_a_rs1, op_a_pc} op_a_sel_t;
  typedef enum logic {op_b_rs2, op_b_imm} op_b_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_t;
  typedef enum logic [1:0] {npc_plus4, npc_branch, npc_jalr} next_pc_sel_t;

  // funct3 for OP and OP-IMM
  localparam logic [funct3_width-1:0] f3_add_sub = 3'b000;
  localparam logic [funct3_width-1:0] f3_sll     = 3'b001;
  localparam logic [funct3_width-1:0] f3_slt     = 3'b010;
  localparam logic [funct3_width-1:0] f3_sltu    = 3'b011;
  localparam logic [funct3_width-1:0] f3_xor     = 3'b100;
  localparam logic [funct3_width-1:0] f3_srl_sra = 3'b101;
  localparam logic [funct3_width-1:0] f3_or      = 3'b110;
  localparam logic [funct3_width-1:0] f3_and     = 3'b111;

  // funct3 for conditional branches
  localparam logic [funct3_width-1:0] f3_beq  = 3'b000;
  localparam logic [funct3_width-1:0] f3_bne  = 3'b001;
  localparam logic [funct3_width-1:0] f3_blt  = 3'b100;
  localparam logic [funct3_width-1:0] f3_bge  = 3'b101;
  localparam logic [funct3_width-1:0] f3_bltu = 3'b110;
  localparam logic [funct3_width-1:0] f3_bgeu = 3'b111;

  // Load/store access formats
  localparam logic [funct3_width-1:0] fmt_byte   = 3'b000;
  localparam logic [funct3_width-1:0] fmt_half   = 3'b001;
  localparam logic [funct3_width-1:0] fmt_word   = 3'b010;
  localparam logic [funct3_width-1:0] fmt_byte_u = 3'b100;
  localparam logic [funct3_width-1:0] fmt_half_u = 3'b101;

endpackage
